// ==== Bender.yml ====
package:
  name: accum_block_looper

sources:
  - include_dirs:
      - include
    files:
      - hdl/accum_pkg.sv
      - hdl/accum_if.sv
      - hdl/accum_loop_ctrl.sv
      - hdl/accum_grid_stepper.sv
      - hdl/accum_id_iter.sv
      - hdl/accum_mofs_gen.sv
      - hdl/accum_block_looper.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/accum_block_looper_checker.sv
      - dv/tb_accum_block_looper.sv

// ==== dv/accum_block_looper_checker.sv ====
// Block looper handshake checks
`timescale 1ns/1ps
`include "accum_settings.svh"

module accum_block_looper_checker (
	input logic               i_clk,
	input logic               i_arst_n,
	input logic               i_src_rdy,
	input logic               o_src_ack,
	input logic               i_mofs_done,
	input logic               o_abofs_rdy,
	input logic               i_abofs_ack,
	input accum_pkg::work_t   o_bofs  [`ACC_DIM],
	input accum_pkg::work_t   o_aofs  [`ACC_DIM],
	input accum_pkg::work_t   o_alast [`ACC_DIM],
	input logic               o_mofs_rdy,
	input logic               i_mofs_ack,
	input accum_pkg::gaddr_t  o_mofs,
	input accum_pkg::cfg_id_t o_id
);
	localparam int DIM = `ACC_DIM;
	localparam int WBW = `ACC_WORK_BW;

	logic [3*DIM*WBW-1:0] abofs_data;
	logic [$bits(accum_pkg::gaddr_t)+$bits(accum_pkg::cfg_id_t)-1:0] mofs_data;
	int unsigned          fail_count = 0;

	// Flat copies of the output payloads
	always_comb begin
		for (int i = 0; i < DIM; i++) begin
			abofs_data[i*WBW +: WBW] = o_bofs[i];
			abofs_data[(DIM+i)*WBW +: WBW] = o_aofs[i];
			abofs_data[(2*DIM+i)*WBW +: WBW] = o_alast[i];
		end
	end
	assign mofs_data = {o_mofs, o_id};

	// ==============================
	// Reset
	// ==============================
	// First clock after release, before any block arrives
	assert property (@(posedge i_clk)
		$rose(i_arst_n) |->
		!o_abofs_rdy && !o_mofs_rdy && !o_src_ack && !i_mofs_done)
	else begin
		fail_count++;
		$error("Outputs active right after reset");
	end

	// ==============================
	// Output handshakes
	// ==============================
	// Stalled abofs item holds until taken
	assert property (@(posedge i_clk) disable iff (!i_arst_n)
		o_abofs_rdy && !i_abofs_ack |=> o_abofs_rdy && $stable(abofs_data))
	else begin
		fail_count++;
		$error("abofs item dropped or changed while stalled");
	end

	assert property (@(posedge i_clk) disable iff (!i_arst_n)
		o_mofs_rdy && !i_mofs_ack |=> o_mofs_rdy && $stable(mofs_data))
	else begin
		fail_count++;
		$error("mofs item dropped or changed while stalled");
	end

	// ==============================
	// Block source
	// ==============================
	assert property (@(posedge i_clk) disable iff (!i_arst_n)
		o_src_ack |-> i_src_rdy)
	else begin
		fail_count++;
		$error("src ack raised without a pending block");
	end

	// Single cycle pulse
	assert property (@(posedge i_clk) disable iff (!i_arst_n)
		o_src_ack |=> !o_src_ack)
	else begin
		fail_count++;
		$error("src ack held longer than one cycle");
	end

endmodule

// Attached to the top level with the internal done pulse
bind accum_block_looper accum_block_looper_checker chk (
	.i_clk       (i_clk),
	.i_arst_n    (i_arst_n),
	.i_src_rdy   (i_src_rdy),
	.o_src_ack   (o_src_ack),
	.i_mofs_done (mofs_done),
	.o_abofs_rdy (o_abofs_rdy),
	.i_abofs_ack (i_abofs_ack),
	.o_bofs      (o_bofs),
	.o_aofs      (o_aofs),
	.o_alast     (o_alast),
	.o_mofs_rdy  (o_mofs_rdy),
	.i_mofs_ack  (i_mofs_ack),
	.o_mofs      (o_mofs),
	.o_id        (o_id)
);

// ==== dv/tb_accum_block_looper.sv ====
// Block looper testbench
`timescale 1ns/1ps
`include "accum_settings.svh"

module tb_accum_block_looper;
	localparam int NBLK = 3;
	localparam int BLK_TIMEOUT = 1000;

	typedef logic [3*`ACC_DIM*`ACC_WORK_BW-1:0] abofs_item_t;
	typedef logic [$bits(accum_pkg::gaddr_t)+$bits(accum_pkg::cfg_id_t)-1:0] mofs_item_t;

	logic               i_clk;
	logic               i_arst_n;
	logic               i_src_rdy;
	logic               o_src_ack;
	accum_pkg::work_t   i_bofs        [`ACC_DIM];
	accum_pkg::shamt_t  i_agrid_shamt [`ACC_DIM];
	accum_pkg::work_t   i_agrid_last  [`ACC_DIM];
	accum_pkg::work_t   i_alocal_last [`ACC_DIM];
	accum_pkg::work_t   i_aboundary   [`ACC_DIM];
	accum_pkg::gaddr_t  i_mofs_starts [`ACC_N_CFG];
	accum_pkg::gaddr_t  i_mofs_asteps [`ACC_N_CFG][`ACC_DIM];
	accum_pkg::cfg_id_t i_id_begs     [`ACC_DIM+1];
	accum_pkg::cfg_id_t i_id_ends     [`ACC_DIM+1];
	logic               o_abofs_rdy;
	logic               i_abofs_ack;
	accum_pkg::work_t   o_bofs  [`ACC_DIM];
	accum_pkg::work_t   o_aofs  [`ACC_DIM];
	accum_pkg::work_t   o_alast [`ACC_DIM];
	logic               o_mofs_rdy;
	logic               i_mofs_ack;
	accum_pkg::gaddr_t  o_mofs;
	accum_pkg::cfg_id_t o_id;

	accum_pkg::work_t bofs_tab [NBLK][`ACC_DIM] = '{'{10, 20}, '{100, 200}, '{513, 7}};
	abofs_item_t      abofs_q [$];
	mofs_item_t       mofs_q [$];
	logic [31:0]      lfsr = 32'hc9b7;
	int               src_ack_count = 0;
	int               abofs_seen = 0;
	int               mofs_seen = 0;

	accum_block_looper uut (.*);

	initial begin
		i_clk = 1'b0;
		forever #4 i_clk = ~i_clk;
	end

	// ==============================
	// Helpers
	// ==============================
	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TEST FAIL");
		$fatal(1, "Simulation stopped on error");
	endtask

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bit(output logic b);
		lfsr = lfsr_step(lfsr);
		b = lfsr[0];
	endtask

	function automatic int clamp_last(input int ofs, input int loc, input int bound);
		return (ofs + loc > bound) ? bound : ofs + loc;
	endfunction

	// Expected streams of one block with dimension 0 innermost
	task automatic build_expected(input int blk);
		int a0;
		int a1;
		int sel;
		int l0;
		int l1;
		accum_pkg::gaddr_t mofs;
		for (a1 = 0; a1 <= i_agrid_last[1]; a1 += 1 << i_agrid_shamt[1]) begin
			for (a0 = 0; a0 <= i_agrid_last[0]; a0 += 1 << i_agrid_shamt[0]) begin
				// Count of wrapped dimensions picks the id range
				if (a0 == 0 && a1 == 0)
					sel = 2;
				else if (a0 == 0)
					sel = 1;
				else
					sel = 0;
				l0 = clamp_last(a0, i_alocal_last[0], i_aboundary[0]);
				l1 = clamp_last(a1, i_alocal_last[1], i_aboundary[1]);
				abofs_q.push_back({bofs_tab[blk][1], bofs_tab[blk][0],
					accum_pkg::work_t'(a1), accum_pkg::work_t'(a0),
					accum_pkg::work_t'(l1), accum_pkg::work_t'(l0)});
				for (int c = i_id_begs[sel]; c < i_id_ends[sel]; c++) begin
					mofs = i_mofs_starts[c] + (a0 >> i_agrid_shamt[0]) * i_mofs_asteps[c][0] +
						(a1 >> i_agrid_shamt[1]) * i_mofs_asteps[c][1];
					mofs_q.push_back({mofs, accum_pkg::cfg_id_t'(c)});
				end
			end
		end
	endtask

	task automatic present_block(input int blk);
		build_expected(blk);
		i_src_rdy <= 1'b1;
		i_bofs <= bofs_tab[blk];
	endtask

	task automatic wait_block_done(input int blk);
		int cycles;
		cycles = 0;
		do begin
			@(negedge i_clk);
			cycles++;
			if (cycles > BLK_TIMEOUT)
				abort_run($sformatf("Timeout: block %0d got no src ack in %0d cycles",
					blk, BLK_TIMEOUT));
		end while (!o_src_ack);
	endtask

	// ==============================
	// Stimulus
	// ==============================
	initial begin
		i_arst_n = 1'b0;
		i_src_rdy = 1'b0;
		i_abofs_ack = 1'b0;
		i_mofs_ack = 1'b0;
		i_bofs = '{default: '0};
		i_agrid_shamt = '{3'd1, 3'd0};
		i_agrid_last = '{10'd6, 10'd2};
		i_alocal_last = '{10'd3, 10'd1};
		// Cuts alast short at the grid edge
		i_aboundary = '{10'd7, 10'd2};
		for (int c = 0; c < `ACC_N_CFG; c++) begin
			i_mofs_starts[c] = 16'h0100 * (c + 1);
			i_mofs_asteps[c][0] = c + 1;
			i_mofs_asteps[c][1] = 16 * (c + 1) + 3;
		end
		// Range for sel 1 is empty
		i_id_begs = '{3'd1, 3'd2, 3'd0};
		i_id_ends = '{3'd3, 3'd2, 3'd4};
		repeat (8) @(posedge i_clk);
		i_arst_n <= 1'b1;
		@(posedge i_clk);
		present_block(0);
		for (int blk = 0; blk < NBLK; blk++) begin
			wait_block_done(blk);
			@(posedge i_clk);
			if (blk + 1 < NBLK)
				present_block(blk + 1);
			else
				i_src_rdy <= 1'b0;
		end
		repeat (4) @(posedge i_clk);
		if (uut.chk.fail_count != 0 || src_ack_count != NBLK ||
		    abofs_q.size() != 0 || mofs_q.size() != 0)
			abort_run("Run ended with a failed assertion or missing items");
		else begin
			$display("TEST PASS");
			$finish;
		end
	end

	// Random back-pressure on both outputs
	always @(posedge i_clk) begin : drive_acks
		logic b0;
		logic b1;
		take_bit(b0);
		take_bit(b1);
		i_abofs_ack <= b0 | b1;
		take_bit(b0);
		take_bit(b1);
		i_mofs_ack <= b0 | b1;
	end

	// ==============================
	// Monitors
	// ==============================
	always @(negedge i_clk) begin : check_abofs
		abofs_item_t exp;
		if (i_arst_n && o_abofs_rdy && i_abofs_ack) begin
			if (abofs_q.size() == 0)
				abort_run($sformatf("FAIL at %0t ns: unexpected abofs item", $time));
			else begin
				exp = abofs_q.pop_front();
				assert ({o_bofs[1], o_bofs[0], o_aofs[1], o_aofs[0],
					o_alast[1], o_alast[0]} == exp)
				else abort_run($sformatf("FAIL at %0t ns: abofs item %0d expected %h",
					$time, abofs_seen, exp));
				abofs_seen++;
			end
		end
	end

	always @(negedge i_clk) begin : check_mofs
		mofs_item_t exp;
		if (i_arst_n && o_mofs_rdy && i_mofs_ack) begin
			if (mofs_q.size() == 0)
				abort_run($sformatf("FAIL at %0t ns: unexpected mofs item id %0d", $time, o_id));
			else begin
				exp = mofs_q.pop_front();
				assert ({o_mofs, o_id} == exp)
				else abort_run($sformatf("FAIL at %0t ns: mofs item %0d got %h expected %h",
					$time, mofs_seen, {o_mofs, o_id}, exp));
				mofs_seen++;
			end
		end
	end

	// Block ends only after all of its items are out
	always @(negedge i_clk) begin : check_src_ack
		if (i_arst_n && o_src_ack) begin
			assert (abofs_q.size() == 0 && mofs_q.size() == 0)
			else abort_run($sformatf("FAIL at %0t ns: src ack with items outstanding", $time));
			src_ack_count++;
		end
		if (uut.chk.fail_count != 0)
			abort_run("A handshake or reset assertion in the checker failed");
	end

endmodule

// ==== files.f ====
+incdir+include
hdl/accum_pkg.sv
hdl/accum_if.sv
hdl/accum_loop_ctrl.sv
hdl/accum_grid_stepper.sv
hdl/accum_id_iter.sv
hdl/accum_mofs_gen.sv
hdl/accum_block_looper.sv
dv/accum_block_looper_checker.sv
dv/tb_accum_block_looper.sv

// ==== hdl/accum_block_looper.sv ====
// Accumulation block looper
`timescale 1ns/1ps
`include "accum_settings.svh"

module accum_block_looper (
	input  logic               i_clk,
	input  logic               i_arst_n,
	input  logic               i_src_rdy,
	output logic               o_src_ack,
	input  accum_pkg::work_t   i_bofs        [`ACC_DIM],
	input  accum_pkg::shamt_t  i_agrid_shamt [`ACC_DIM],
	input  accum_pkg::work_t   i_agrid_last  [`ACC_DIM],
	input  accum_pkg::work_t   i_alocal_last [`ACC_DIM],
	input  accum_pkg::work_t   i_aboundary   [`ACC_DIM],
	input  accum_pkg::gaddr_t  i_mofs_starts [`ACC_N_CFG],
	input  accum_pkg::gaddr_t  i_mofs_asteps [`ACC_N_CFG][`ACC_DIM],
	input  accum_pkg::cfg_id_t i_id_begs     [`ACC_DIM+1],
	input  accum_pkg::cfg_id_t i_id_ends     [`ACC_DIM+1],
	output logic               o_abofs_rdy,
	input  logic               i_abofs_ack,
	output accum_pkg::work_t   o_bofs  [`ACC_DIM],
	output accum_pkg::work_t   o_aofs  [`ACC_DIM],
	output accum_pkg::work_t   o_alast [`ACC_DIM],
	output logic               o_mofs_rdy,
	input  logic               i_mofs_ack,
	output accum_pkg::gaddr_t  o_mofs,
	output accum_pkg::cfg_id_t o_id
);
	logic start;
	logic mofs_done;

	// ==============================
	// Internal links
	// ==============================
	grid_step_if step_gen();
	grid_step_if step_fwd();
	mofs_req_if  mofs_req();

	accum_grid_stepper u_stepper (
		.i_clk         (i_clk),
		.i_arst_n      (i_arst_n),
		.i_start       (start),
		.i_agrid_shamt (i_agrid_shamt),
		.i_agrid_last  (i_agrid_last),
		.step          (step_gen.src)
	);

	accum_loop_ctrl u_ctrl (
		.i_clk         (i_clk),
		.i_arst_n      (i_arst_n),
		.i_src_rdy     (i_src_rdy),
		.o_src_ack     (o_src_ack),
		.i_bofs        (i_bofs),
		.i_alocal_last (i_alocal_last),
		.i_aboundary   (i_aboundary),
		.o_start       (start),
		.step_in       (step_gen.dst),
		.step_out      (step_fwd.src),
		.o_abofs_rdy   (o_abofs_rdy),
		.i_abofs_ack   (i_abofs_ack),
		.o_bofs        (o_bofs),
		.o_aofs        (o_aofs),
		.o_alast       (o_alast),
		.i_mofs_done   (mofs_done)
	);

	accum_id_iter u_id_iter (
		.i_clk     (i_clk),
		.i_arst_n  (i_arst_n),
		.i_id_begs (i_id_begs),
		.i_id_ends (i_id_ends),
		.step      (step_fwd.dst),
		.req       (mofs_req.src)
	);

	accum_mofs_gen u_mofs_gen (
		.i_clk         (i_clk),
		.i_arst_n      (i_arst_n),
		.i_mofs_starts (i_mofs_starts),
		.i_mofs_asteps (i_mofs_asteps),
		.i_agrid_shamt (i_agrid_shamt),
		.req           (mofs_req.dst),
		.o_mofs_rdy    (o_mofs_rdy),
		.i_mofs_ack    (i_mofs_ack),
		.o_mofs        (o_mofs),
		.o_id          (o_id),
		.o_done        (mofs_done)
	);

endmodule

// ==== hdl/accum_grid_stepper.sv ====
// Accumulation grid stepper
`timescale 1ns/1ps
`include "accum_settings.svh"

module accum_grid_stepper (
	input  logic               i_clk,
	input  logic               i_arst_n,
	input  logic               i_start,
	input  accum_pkg::shamt_t  i_agrid_shamt [`ACC_DIM],
	input  accum_pkg::work_t   i_agrid_last  [`ACC_DIM],
	grid_step_if.src           step
);
	localparam int DIM = `ACC_DIM;
	localparam int WBW = `ACC_WORK_BW;

	logic [WBW:0]         nxt_sum [DIM];
	logic [DIM-1:0]       wrap;
	accum_pkg::work_t     nxt_ofs [DIM];
	accum_pkg::dim_flag_t nxt_reset;
	accum_pkg::dim_flag_t nxt_add;
	accum_pkg::sel_t      nxt_sel;
	logic                 carry;
	logic                 step_fire;

	// ==============================
	// Odometer advance
	// ==============================
	// Dimension 0 is innermost, carry ripples outward
	always_comb begin
		carry = 1'b1;
		nxt_sel = '0;
		nxt_reset = '0;
		nxt_add = '0;
		for (int d = 0; d < DIM; d++) begin
			nxt_sum[d] = {1'b0, step.aofs[d]} + ({{WBW{1'b0}}, 1'b1} << i_agrid_shamt[d]);
			wrap[d] = nxt_sum[d] > {1'b0, i_agrid_last[d]};
			nxt_ofs[d] = step.aofs[d];
			if (carry) begin
				if (wrap[d]) begin
					nxt_ofs[d] = '0;
					nxt_reset[d] = 1'b1;
					nxt_sel = nxt_sel + 1'b1;
				end else begin
					nxt_ofs[d] = nxt_sum[d][WBW-1:0];
					nxt_add[d] = 1'b1;
					carry = 1'b0;
				end
			end
		end
	end

	// Every dimension would wrap on the next advance
	assign step.islast = &wrap;
	assign step_fire = step.rdy && step.ack;

	// ==============================
	// Output point
	// ==============================
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			step.rdy <= 1'b0;
		end else if (i_start) begin
			step.rdy <= 1'b1;
		end else if (step_fire) begin
			step.rdy <= !step.islast;
		end
	end

	// First point clears every accumulator dimension
	always_ff @(posedge i_clk) begin
		if (i_start) begin
			step.aofs <= '{default: '0};
			step.reset_flag <= '1;
			step.add_flag <= '0;
			step.sel <= accum_pkg::sel_t'(DIM);
		end else if (step_fire) begin
			step.aofs <= nxt_ofs;
			step.reset_flag <= nxt_reset;
			step.add_flag <= nxt_add;
			step.sel <= nxt_sel;
		end
	end

endmodule

// ==== hdl/accum_id_iter.sv ====
// Configuration id iterator
`timescale 1ns/1ps
`include "accum_settings.svh"

module accum_id_iter (
	input  logic               i_clk,
	input  logic               i_arst_n,
	input  accum_pkg::cfg_id_t i_id_begs [`ACC_DIM+1],
	input  accum_pkg::cfg_id_t i_id_ends [`ACC_DIM+1],
	grid_step_if.dst           step,
	mofs_req_if.src            req
);
	accum_pkg::cfg_id_t beg_sel;
	accum_pkg::cfg_id_t end_sel;
	accum_pkg::cfg_id_t id_end;
	logic               blk_last;
	logic               step_last;
	logic               req_fire;

	// ==============================
	// Range lookup
	// ==============================
	assign beg_sel = i_id_begs[step.sel];
	assign end_sel = i_id_ends[step.sel];

	// Current request closes its grid point
	assign step_last = req.update_only || (req.id + 1'b1 == id_end);
	assign req.islast = blk_last && step_last;
	assign req_fire = req.rdy && req.ack;

	// Take the next point as the last id of this one leaves
	assign step.ack = step.rdy && (!req.rdy || (req_fire && step_last));

	// ==============================
	// Request walk
	// ==============================
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			req.rdy <= 1'b0;
		end else if (step.ack) begin
			req.rdy <= 1'b1;
		end else if (req_fire && step_last) begin
			req.rdy <= 1'b0;
		end
	end

	always_ff @(posedge i_clk) begin
		if (step.ack) begin
			req.id <= beg_sel;
			id_end <= end_sel;
			req.reset_flag <= step.reset_flag;
			req.add_flag <= step.add_flag;
			// Empty range still moves the accumulators
			req.update_only <= (beg_sel >= end_sel);
			blk_last <= step.islast;
		end else if (req_fire) begin
			req.id <= req.id + 1'b1;
			// flags go with the first id only
			req.reset_flag <= '0;
			req.add_flag <= '0;
		end
	end

endmodule

// ==== hdl/accum_if.sv ====
// Grid step and memory request links
`timescale 1ns/1ps
`include "accum_settings.svh"

// One grid point with its accumulator flags
interface grid_step_if;
	logic                 rdy;
	logic                 ack;
	accum_pkg::work_t     aofs [`ACC_DIM];
	accum_pkg::dim_flag_t reset_flag;
	accum_pkg::dim_flag_t add_flag;
	accum_pkg::sel_t      sel;
	// Final point of the block
	logic                 islast;

	modport src(output rdy, aofs, reset_flag, add_flag, sel, islast, input ack);
	modport dst(input rdy, aofs, reset_flag, add_flag, sel, islast, output ack);
endinterface

// One memory offset request for a configuration id
interface mofs_req_if;
	logic                 rdy;
	logic                 ack;
	accum_pkg::cfg_id_t   id;
	accum_pkg::dim_flag_t reset_flag;
	accum_pkg::dim_flag_t add_flag;
	// Accumulator update only, no memory offset goes out
	logic                 update_only;
	logic                 islast;

	modport src(
		output rdy, id, reset_flag, add_flag, update_only, islast,
		input ack
	);
	modport dst(
		input rdy, id, reset_flag, add_flag, update_only, islast,
		output ack
	);
endinterface

// ==== hdl/accum_loop_ctrl.sv ====
// Accumulation loop control
`timescale 1ns/1ps
`include "accum_settings.svh"

module accum_loop_ctrl (
	input  logic             i_clk,
	input  logic             i_arst_n,
	input  logic             i_src_rdy,
	output logic             o_src_ack,
	input  accum_pkg::work_t i_bofs        [`ACC_DIM],
	input  accum_pkg::work_t i_alocal_last [`ACC_DIM],
	input  accum_pkg::work_t i_aboundary   [`ACC_DIM],
	output logic             o_start,
	grid_step_if.dst         step_in,
	grid_step_if.src         step_out,
	output logic             o_abofs_rdy,
	input  logic             i_abofs_ack,
	output accum_pkg::work_t o_bofs  [`ACC_DIM],
	output accum_pkg::work_t o_aofs  [`ACC_DIM],
	output accum_pkg::work_t o_alast [`ACC_DIM],
	input  logic             i_mofs_done
);
	localparam int DIM = `ACC_DIM;
	localparam int WBW = `ACC_WORK_BW;

	accum_pkg::loop_state_e state;
	accum_pkg::loop_state_e state_nxt;
	accum_pkg::work_t       bofs_q [DIM];
	logic                   abofs_taken;
	logic                   iter_taken;
	logic                   abofs_ok;
	logic                   iter_ok;
	logic                   step_fire;
	logic                   last_passed;
	logic                   mofs_finished;
	logic [WBW:0]           alast_sum [DIM];

	// ==============================
	// Block FSM
	// ==============================
	always_comb begin
		state_nxt = state;
		case (state)
			accum_pkg::IDLE: begin
				if (i_src_rdy)
					state_nxt = accum_pkg::RUN;
			end
			accum_pkg::RUN: begin
				if ((last_passed || (step_fire && step_in.islast)) &&
				    (mofs_finished || i_mofs_done))
					state_nxt = accum_pkg::FINISH;
			end
			default: state_nxt = accum_pkg::IDLE;
		endcase
	end

	assign o_start = (state == accum_pkg::IDLE) && i_src_rdy;
	assign o_src_ack = (state == accum_pkg::FINISH);

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state <= accum_pkg::IDLE;
			last_passed <= 1'b0;
			mofs_finished <= 1'b0;
		end else begin
			state <= state_nxt;
			if (state == accum_pkg::FINISH) begin
				last_passed <= 1'b0;
				mofs_finished <= 1'b0;
			end else begin
				if (step_fire && step_in.islast)
					last_passed <= 1'b1;
				if (i_mofs_done)
					mofs_finished <= 1'b1;
			end
		end
	end

	// Block offset is held for the whole block
	always_ff @(posedge i_clk) begin
		if (o_start)
			bofs_q <= i_bofs;
	end
	assign o_bofs = bofs_q;

	// ==============================
	// Fork to abofs and id iterator
	// ==============================
	assign o_abofs_rdy = step_in.rdy && !abofs_taken;
	assign step_out.rdy = step_in.rdy && !iter_taken;
	assign abofs_ok = abofs_taken || (o_abofs_rdy && i_abofs_ack);
	assign iter_ok = iter_taken || (step_out.rdy && step_out.ack);
	assign step_in.ack = step_in.rdy && abofs_ok && iter_ok;
	assign step_fire = step_in.ack;

	// Remember a branch that took the point early
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			abofs_taken <= 1'b0;
			iter_taken <= 1'b0;
		end else if (step_fire) begin
			abofs_taken <= 1'b0;
			iter_taken <= 1'b0;
		end else begin
			abofs_taken <= abofs_ok;
			iter_taken <= iter_ok;
		end
	end

	assign step_out.aofs = step_in.aofs;
	assign step_out.reset_flag = step_in.reset_flag;
	assign step_out.add_flag = step_in.add_flag;
	assign step_out.sel = step_in.sel;
	assign step_out.islast = step_in.islast;
	assign o_aofs = step_in.aofs;

	// Local last clamped to the boundary
	always_comb begin
		for (int i = 0; i < DIM; i++) begin
			alast_sum[i] = {1'b0, step_in.aofs[i]} + {1'b0, i_alocal_last[i]};
			if (alast_sum[i] > {1'b0, i_aboundary[i]})
				o_alast[i] = i_aboundary[i];
			else
				o_alast[i] = alast_sum[i][WBW-1:0];
		end
	end

endmodule

// ==== hdl/accum_mofs_gen.sv ====
// Memory offset generator
`timescale 1ns/1ps
`include "accum_settings.svh"

module accum_mofs_gen (
	input  logic               i_clk,
	input  logic               i_arst_n,
	input  accum_pkg::gaddr_t  i_mofs_starts [`ACC_N_CFG],
	input  accum_pkg::gaddr_t  i_mofs_asteps [`ACC_N_CFG][`ACC_DIM],
	input  accum_pkg::shamt_t  i_agrid_shamt [`ACC_DIM],
	mofs_req_if.dst            req,
	output logic               o_mofs_rdy,
	input  logic               i_mofs_ack,
	output accum_pkg::gaddr_t  o_mofs,
	output accum_pkg::cfg_id_t o_id,
	output logic               o_done
);
	localparam int DIM = `ACC_DIM;
	localparam int NCFG = `ACC_N_CFG;
	localparam int GBW = `ACC_GADDR_BW;
	// Extra bits for the largest grid step shift
	localparam int ABW = GBW + (1 << `ACC_SHAMT_BW) - 1;

	logic [ABW-1:0]    acc     [NCFG][DIM];
	logic [ABW-1:0]    acc_nxt [NCFG][DIM];
	accum_pkg::gaddr_t sum_nxt;
	logic              req_fire;
	logic              out_fire;
	logic              out_islast;

	assign out_fire = o_mofs_rdy && i_mofs_ack;
	// Hold off while the output register is still owed
	assign req.ack = req.rdy && (!o_mofs_rdy || i_mofs_ack);
	assign req_fire = req.rdy && req.ack;

	// ==============================
	// Accumulators
	// ==============================
	// Accumulators run in grid offset units, shifted back per dimension
	always_comb begin
		sum_nxt = '0;
		for (int c = 0; c < NCFG; c++) begin
			for (int d = 0; d < DIM; d++) begin
				acc_nxt[c][d] = acc[c][d];
				if (req.reset_flag[d])
					acc_nxt[c][d] = '0;
				else if (req.add_flag[d])
					acc_nxt[c][d] = acc[c][d] +
						({{(ABW-GBW){1'b0}}, i_mofs_asteps[c][d]} << i_agrid_shamt[d]);
			end
			if (accum_pkg::cfg_id_t'(c) == req.id) begin
				sum_nxt = i_mofs_starts[c];
				for (int d = 0; d < DIM; d++)
					sum_nxt = sum_nxt + accum_pkg::gaddr_t'(acc_nxt[c][d] >> i_agrid_shamt[d]);
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (req_fire)
			acc <= acc_nxt;
	end

	// ==============================
	// Output register
	// ==============================
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_mofs_rdy <= 1'b0;
		end else if (req_fire && !req.update_only) begin
			o_mofs_rdy <= 1'b1;
		end else if (out_fire) begin
			o_mofs_rdy <= 1'b0;
		end
	end

	always_ff @(posedge i_clk) begin
		if (req_fire && !req.update_only) begin
			o_mofs <= sum_nxt;
			o_id <= req.id;
			out_islast <= req.islast;
		end
	end

	// Block done on the last presented item or an absorbed final update
	assign o_done = (out_fire && out_islast) ||
		(req_fire && req.update_only && req.islast);

endmodule

// ==== hdl/accum_pkg.sv ====
// Accumulation loop types
`include "accum_settings.svh"

package accum_pkg;

	// ==============================
	// Vector types
	// ==============================
	typedef logic [`ACC_WORK_BW-1:0] work_t;
	typedef logic [`ACC_GADDR_BW-1:0] gaddr_t;
	// Must hold the value N_CFG itself as an open range end
	typedef logic [$clog2(`ACC_N_CFG+1)-1:0] cfg_id_t;
	typedef logic [`ACC_SHAMT_BW-1:0] shamt_t;
	typedef logic [`ACC_DIM-1:0] dim_flag_t;
	// Range selector 0 to DIM
	typedef logic [$clog2(`ACC_DIM+1)-1:0] sel_t;

	// ==============================
	// Control FSM
	// ==============================
	typedef enum logic [1:0] {
		IDLE,
		RUN,
		FINISH
	} loop_state_e;

endpackage

// ==== include/accum_settings.svh ====
// Accumulation loop settings
`ifndef ACCUM_SETTINGS_SVH
`define ACCUM_SETTINGS_SVH

// ==============================
// Grid and configuration
// ==============================
`define ACC_DIM 2
`define ACC_N_CFG 4

// ==============================
// Widths
// ==============================
// Grid offsets and bounds
`define ACC_WORK_BW 10
// Memory offsets and steps
`define ACC_GADDR_BW 16
// Grid step shift amount
`define ACC_SHAMT_BW 3

`endif
